// File: common/cpu_pkg.sv
// cpu shared definitions
`default_nettype none

package cpu_pkg;

    localparam int DATA_W  = 16;
    localparam int REG_AW  = 3;
    localparam int IMM_W   = 6;
    localparam int IMEM_AW = 6;
    localparam int DMEM_AW = 6;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_t;

    // opcode sits in bits 15:12, unlisted values are illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,
        OP_LD   = 4'h5,
        OP_ST   = 4'h6,
        OP_HALT = 4'h7
    } opcode_e;

    // register format
    typedef struct packed {
        opcode_e    op;
        reg_t       rd;
        reg_t       rs;
        reg_t       rt;
        logic [2:0] unused;
    } r_fmt_t;

    // immediate format, 6-bit signed immediate
    typedef struct packed {
        opcode_e                 op;
        reg_t                    rd;
        reg_t                    rs;
        logic signed [IMM_W-1:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_e;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: common/stage_if.sv
// pipeline stage bundles
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    logic              valid;
    cpu_pkg::alu_op_e  alu_op;
    logic              use_imm;
    cpu_pkg::word_t    imm;
    cpu_pkg::reg_t     rs;
    cpu_pkg::reg_t     rt;
    cpu_pkg::reg_t     rd;
    cpu_pkg::word_t    vs;
    cpu_pkg::word_t    vt;
    logic              rf_wen;
    logic              dmem_ren;
    logic              dmem_wen;
    logic              halt;

    modport src  (output valid, alu_op, use_imm, imm, rs, rt, rd, vs, vt,
                         rf_wen, dmem_ren, dmem_wen, halt);
    modport sink (input  valid, alu_op, use_imm, imm, rd, vs, vt,
                         rf_wen, dmem_ren, dmem_wen, halt);
    // hazard unit view
    modport mon  (input  valid, rs, rt, rd, dmem_ren);
endinterface

interface ex_mem_if;
    logic              valid;
    cpu_pkg::word_t    alu_out;
    cpu_pkg::word_t    store_data;
    cpu_pkg::reg_t     rd;
    logic              rf_wen;
    logic              dmem_ren;
    logic              dmem_wen;
    logic              halt;

    modport src  (output valid, alu_out, store_data, rd, rf_wen, dmem_ren, dmem_wen, halt);
    modport sink (input  valid, alu_out, store_data, rd, rf_wen, dmem_ren, dmem_wen, halt);
    modport mon  (input  valid, rd, rf_wen);
endinterface

`default_nettype wire

// File: fetch/fetch.sv
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_imem_we,
    input  logic [cpu_pkg::IMEM_AW-1:0]  i_imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0]   i_imem_data,
    input  logic                         i_start,
    input  logic                         i_stall,
    output logic                         o_valid,
    output cpu_pkg::instr_t              o_instr,
    output logic                         o_err
);

    cpu_pkg::instr_t imem [0:2**cpu_pkg::IMEM_AW-1];

    // top bit set means the pc ran off the end
    logic [cpu_pkg::IMEM_AW:0] pc;
    logic                      run;
    logic                      fire;
    cpu_pkg::instr_t           word;

    assign word  = imem[pc[cpu_pkg::IMEM_AW-1:0]];
    assign fire  = run && !i_stall && !pc[cpu_pkg::IMEM_AW];
    assign o_err = run && pc[cpu_pkg::IMEM_AW];

    // program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            run     <= 1'b0;
            pc      <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_start && !run) begin
                run <= 1'b1;
                pc  <= '0;
            end else if (fire) begin
                pc <= pc + 1'b1;
                // stop right after the halt word
                if (word.r_fmt.op == cpu_pkg::OP_HALT) begin
                    run <= 1'b0;
                end
            end
            if (!i_stall) begin
                o_valid <= fire;
            end
        end
    end

    // IF/ID word, held on a stall
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_instr <= word;
        end
    end

    a_no_load_while_running: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) run |-> !i_imem_we
    );

endmodule

`default_nettype wire

// File: decode/decode.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_valid,
    input  cpu_pkg::instr_t  i_instr,
    input  logic             i_stall,
    input  logic             i_wb_wen,
    input  cpu_pkg::reg_t    i_wb_reg,
    input  cpu_pkg::word_t   i_wb_data,
    id_ex_if.src             o_id_ex,
    output cpu_pkg::reg_t    o_rs,
    output cpu_pkg::reg_t    o_rt,
    output logic             o_err
);

    cpu_pkg::word_t    rf [0:2**cpu_pkg::REG_AW-1];
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    vs;
    cpu_pkg::word_t    vt;
    logic              use_imm;
    logic              rf_wen;
    logic              ren;
    logic              wen;
    logic              halt;
    logic              legal;
    logic              take;

    always_comb begin
        o_rs    = '0;
        o_rt    = '0;
        use_imm = 1'b0;
        rf_wen  = 1'b0;
        ren     = 1'b0;
        wen     = 1'b0;
        halt    = 1'b0;
        legal   = 1'b1;
        case (i_instr.r_fmt.op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_XOR: begin
                o_rs   = i_instr.r_fmt.rs;
                o_rt   = i_instr.r_fmt.rt;
                rf_wen = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LD: begin
                o_rs    = i_instr.i_fmt.rs;
                use_imm = 1'b1;
                rf_wen  = 1'b1;
                ren     = (i_instr.i_fmt.op == cpu_pkg::OP_LD);
            end
            cpu_pkg::OP_ST: begin
                // store data travels on the rt path
                o_rs    = i_instr.i_fmt.rs;
                o_rt    = i_instr.i_fmt.rd;
                use_imm = 1'b1;
                wen     = 1'b1;
            end
            cpu_pkg::OP_HALT: begin
                halt = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (!i_valid) begin
            o_rs = '0;
            o_rt = '0;
        end
    end

    always_comb begin
        case (i_instr.r_fmt.op)
            cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND: alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_XOR: alu_op = cpu_pkg::ALU_XOR;
            default:         alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    assign imm = {{(cpu_pkg::DATA_W-cpu_pkg::IMM_W){i_instr.i_fmt.imm[cpu_pkg::IMM_W-1]}},
                  i_instr.i_fmt.imm};

    // writeback lands in the same cycle it is read
    assign vs = (i_wb_wen && i_wb_reg == o_rs) ? i_wb_data : rf[o_rs];
    assign vt = (i_wb_wen && i_wb_reg == o_rt) ? i_wb_data : rf[o_rt];

    assign o_err = i_valid && !legal;
    // illegal words and stalls go down as bubbles
    assign take  = i_valid && legal && !i_stall;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::REG_AW; i++) begin
                rf[i] <= '0;
            end
        end else if (i_wb_wen) begin
            rf[i_wb_reg] <= i_wb_data;
        end
    end

    // ID/EX control
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_id_ex.valid    <= 1'b0;
            o_id_ex.rf_wen   <= 1'b0;
            o_id_ex.dmem_ren <= 1'b0;
            o_id_ex.dmem_wen <= 1'b0;
            o_id_ex.halt     <= 1'b0;
        end else begin
            o_id_ex.valid    <= take;
            o_id_ex.rf_wen   <= take && rf_wen;
            o_id_ex.dmem_ren <= take && ren;
            o_id_ex.dmem_wen <= take && wen;
            o_id_ex.halt     <= take && halt;
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clk) begin
        o_id_ex.alu_op  <= alu_op;
        o_id_ex.use_imm <= use_imm;
        o_id_ex.imm     <= imm;
        o_id_ex.rs      <= o_rs;
        o_id_ex.rt      <= o_rt;
        o_id_ex.rd      <= i_instr.r_fmt.rd;
        o_id_ex.vs      <= vs;
        o_id_ex.vt      <= vt;
    end

    // r0 stays zero even with writeback dropping r0 writes downstream
    a_r0_reads_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_id_ex.valid && (o_id_ex.rs == '0) |-> (o_id_ex.vs == '0)
    );

endmodule

`default_nettype wire

// File: execute/execute.sv
// execute stage
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic               i_clk,
    input  logic               i_rst_n,
    id_ex_if.sink              i_id_ex,
    input  cpu_pkg::fwd_sel_e  i_fwd_s,
    input  cpu_pkg::fwd_sel_e  i_fwd_t,
    input  cpu_pkg::word_t     i_wb_data,
    ex_mem_if.src              o_ex_mem,
    output logic               o_err
);

    cpu_pkg::word_t op_s;
    cpu_pkg::word_t op_t;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_out;

    function automatic cpu_pkg::word_t pick(input cpu_pkg::fwd_sel_e sel,
                                            input cpu_pkg::word_t    reg_val,
                                            input cpu_pkg::word_t    mem_val,
                                            input cpu_pkg::word_t    wb_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_s = pick(i_fwd_s, i_id_ex.vs, o_ex_mem.alu_out, i_wb_data);
    assign op_t = pick(i_fwd_t, i_id_ex.vt, o_ex_mem.alu_out, i_wb_data);
    assign op_b = i_id_ex.use_imm ? i_id_ex.imm : op_t;

    // also the address for LD and ST
    always_comb begin
        case (i_id_ex.alu_op)
            cpu_pkg::ALU_SUB: alu_out = op_s - op_b;
            cpu_pkg::ALU_AND: alu_out = op_s & op_b;
            cpu_pkg::ALU_XOR: alu_out = op_s ^ op_b;
            default:          alu_out = op_s + op_b;
        endcase
    end

    assign o_err = i_id_ex.valid && i_id_ex.dmem_ren && i_id_ex.dmem_wen;

    // EX/MEM control
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ex_mem.valid    <= 1'b0;
            o_ex_mem.rf_wen   <= 1'b0;
            o_ex_mem.dmem_ren <= 1'b0;
            o_ex_mem.dmem_wen <= 1'b0;
            o_ex_mem.halt     <= 1'b0;
        end else begin
            o_ex_mem.valid    <= i_id_ex.valid;
            o_ex_mem.rf_wen   <= i_id_ex.rf_wen;
            o_ex_mem.dmem_ren <= i_id_ex.dmem_ren;
            o_ex_mem.dmem_wen <= i_id_ex.dmem_wen;
            o_ex_mem.halt     <= i_id_ex.halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_ex_mem.alu_out    <= alu_out;
        o_ex_mem.store_data <= op_t;
        o_ex_mem.rd         <= i_id_ex.rd;
    end

    // the load-use bubble keeps a load address off the memory-stage path
    a_no_fwd_from_load: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_id_ex.valid && (i_fwd_s == cpu_pkg::FWD_MEM || i_fwd_t == cpu_pkg::FWD_MEM)
        |-> !o_ex_mem.dmem_ren
    );

endmodule

`default_nettype wire

// File: memory/memory.sv
// memory stage and writeback select
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  logic            i_clk,
    input  logic            i_rst_n,
    ex_mem_if.sink          i_ex_mem,
    output logic            o_wb_wen,
    output cpu_pkg::reg_t   o_wb_reg,
    output cpu_pkg::word_t  o_wb_data,
    output logic            o_halted,
    output logic            o_err
);

    cpu_pkg::word_t              dmem [0:2**cpu_pkg::DMEM_AW-1];
    logic [cpu_pkg::DMEM_AW-1:0] addr;
    logic                        access;

    assign addr   = i_ex_mem.alu_out[cpu_pkg::DMEM_AW-1:0];
    assign access = i_ex_mem.valid && (i_ex_mem.dmem_ren || i_ex_mem.dmem_wen);
    // upper address bits must be clear
    assign o_err  = access && (i_ex_mem.alu_out[cpu_pkg::DATA_W-1:cpu_pkg::DMEM_AW] != '0);

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.valid && i_ex_mem.dmem_wen) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    // MEM/WB strobes, writes to r0 dropped here
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_wen <= 1'b0;
            o_halted <= 1'b0;
        end else begin
            o_wb_wen <= i_ex_mem.valid && i_ex_mem.rf_wen && (i_ex_mem.rd != '0);
            o_halted <= i_ex_mem.valid && i_ex_mem.halt;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_reg  <= i_ex_mem.rd;
        o_wb_data <= i_ex_mem.dmem_ren ? dmem[addr] : i_ex_mem.alu_out;
    end

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
// forwarding and load-use hazard unit
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_t      i_dec_rs,
    input  cpu_pkg::reg_t      i_dec_rt,
    id_ex_if.mon               i_id_ex,
    ex_mem_if.mon              i_ex_mem,
    input  logic               i_wb_wen,
    input  cpu_pkg::reg_t      i_wb_reg,
    output cpu_pkg::fwd_sel_e  o_fwd_s,
    output cpu_pkg::fwd_sel_e  o_fwd_t,
    output logic               o_stall
);

    logic mem_hit_en;

    // memory stage is younger, so it wins over writeback
    function automatic cpu_pkg::fwd_sel_e fwd_for(input cpu_pkg::reg_t src,
                                                  input logic          mem_en,
                                                  input cpu_pkg::reg_t mem_rd,
                                                  input logic          wb_en,
                                                  input cpu_pkg::reg_t wb_rd);
        if (src == '0) return cpu_pkg::FWD_NONE;
        if (mem_en && mem_rd == src) return cpu_pkg::FWD_MEM;
        if (wb_en && wb_rd == src) return cpu_pkg::FWD_WB;
        return cpu_pkg::FWD_NONE;
    endfunction

    assign mem_hit_en = i_ex_mem.valid && i_ex_mem.rf_wen;

    assign o_fwd_s = fwd_for(i_id_ex.rs, mem_hit_en, i_ex_mem.rd, i_wb_wen, i_wb_reg);
    assign o_fwd_t = fwd_for(i_id_ex.rt, mem_hit_en, i_ex_mem.rd, i_wb_wen, i_wb_reg);

    // load in execute feeding the word in decode
    assign o_stall = i_id_ex.valid && i_id_ex.dmem_ren && (i_id_ex.rd != '0) &&
                     (i_id_ex.rd == i_dec_rs || i_id_ex.rd == i_dec_rt);

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
// five-stage cpu top level
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_imem_we,
    input  logic [cpu_pkg::IMEM_AW-1:0]  i_imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0]   i_imem_data,
    input  logic                         i_start,
    output logic                         o_wb_valid,
    output logic [cpu_pkg::REG_AW-1:0]   o_wb_reg,
    output logic [cpu_pkg::DATA_W-1:0]   o_wb_data,
    output logic                         o_halted,
    output logic                         o_err
);

    logic                if_valid;
    cpu_pkg::instr_t     if_instr;
    cpu_pkg::reg_t       dec_rs;
    cpu_pkg::reg_t       dec_rt;
    cpu_pkg::fwd_sel_e   fwd_s;
    cpu_pkg::fwd_sel_e   fwd_t;
    logic                stall;
    logic                if_err;
    logic                id_err;
    logic                ex_err;
    logic                mem_err;

    // writeback loopback
    logic                wb_wen;
    cpu_pkg::reg_t       wb_reg;
    cpu_pkg::word_t      wb_data;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();

    fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_start     (i_start),
        .i_stall     (stall),
        .o_valid     (if_valid),
        .o_instr     (if_instr),
        .o_err       (if_err)
    );

    decode u_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (if_valid),
        .i_instr   (if_instr),
        .i_stall   (stall),
        .i_wb_wen  (wb_wen),
        .i_wb_reg  (wb_reg),
        .i_wb_data (wb_data),
        .o_id_ex   (u_id_ex),
        .o_rs      (dec_rs),
        .o_rt      (dec_rt),
        .o_err     (id_err)
    );

    execute u_execute (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_id_ex   (u_id_ex),
        .i_fwd_s   (fwd_s),
        .i_fwd_t   (fwd_t),
        .i_wb_data (wb_data),
        .o_ex_mem  (u_ex_mem),
        .o_err     (ex_err)
    );

    memory u_memory (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ex_mem  (u_ex_mem),
        .o_wb_wen  (wb_wen),
        .o_wb_reg  (wb_reg),
        .o_wb_data (wb_data),
        .o_halted  (o_halted),
        .o_err     (mem_err)
    );

    hazard_unit u_hazard (
        .i_dec_rs (dec_rs),
        .i_dec_rt (dec_rt),
        .i_id_ex  (u_id_ex),
        .i_ex_mem (u_ex_mem),
        .i_wb_wen (wb_wen),
        .i_wb_reg (wb_reg),
        .o_fwd_s  (fwd_s),
        .o_fwd_t  (fwd_t),
        .o_stall  (stall)
    );

    assign o_wb_valid = wb_wen;
    assign o_wb_reg   = wb_reg;
    assign o_wb_data  = wb_data;
    assign o_err      = |{if_err, id_err, ex_err, mem_err};

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int PERIOD     = 10;
    localparam int RST_CYCLES = 3;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            o_clk = ~o_clk;
        end
    end

    // reset held low for the first few edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/tb_cpu.sv
// cpu pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int NPROG      = 6;
    localparam int MAXW       = 16;
    localparam int MAXE       = 16;
    localparam int RST_CYCLES = 3;

    logic                         clk;
    logic                         rst_n;
    logic                         imem_we;
    logic [cpu_pkg::IMEM_AW-1:0]  imem_addr;
    cpu_pkg::word_t               imem_data;
    logic                         start;
    logic                         wb_valid;
    cpu_pkg::reg_t                wb_reg;
    cpu_pkg::word_t               wb_data;
    logic                         halted;
    logic                         err;

    // program table
    cpu_pkg::instr_t  prog_word [NPROG][MAXW];
    int               prog_len  [NPROG];
    string            prog_name [NPROG];
    cpu_pkg::reg_t    exp_reg   [NPROG][MAXE];
    cpu_pkg::word_t   exp_data  [NPROG][MAXE];
    int               exp_cnt   [NPROG];
    logic             exp_err   [NPROG];

    // expected register contents carried across runs
    cpu_pkg::word_t   shadow [8];

    int    seed = 32'h2e94ac1b;
    int    total_words;
    int    errors;
    int    pass_count;
    int    fail_count;
    logic  table_ready = 1'b0;

    tb_clock u_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    cpu_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_start     (start),
        .o_wb_valid  (wb_valid),
        .o_wb_reg    (wb_reg),
        .o_wb_data   (wb_data),
        .o_halted    (halted),
        .o_err       (err)
    );

    function automatic logic [5:0] draw_imm(input logic negative);
        logic [31:0] r;
        r = $random(seed);
        if (negative) begin
            r[5] = 1'b1;
        end
        return r[5:0];
    endfunction

    // value of a 6-bit two's complement field taken modulo 2^16
    function automatic cpu_pkg::word_t sext6(input logic [5:0] v);
        if (v[5]) begin
            return {10'd0, v} - 16'd64;
        end
        return {10'd0, v};
    endfunction

    task automatic emit_word(input int p, input cpu_pkg::instr_t w);
        prog_word[p][prog_len[p]] = w;
        prog_len[p]++;
        total_words++;
    endtask

    task automatic emit_r(input int p, input cpu_pkg::opcode_e op, input cpu_pkg::reg_t rd,
                          input cpu_pkg::reg_t rs, input cpu_pkg::reg_t rt);
        cpu_pkg::instr_t w;
        w.r_fmt.op     = op;
        w.r_fmt.rd     = rd;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.unused = 3'b000;
        emit_word(p, w);
    endtask

    task automatic emit_i(input int p, input cpu_pkg::opcode_e op, input cpu_pkg::reg_t rd,
                          input cpu_pkg::reg_t rs, input logic [5:0] imm);
        cpu_pkg::instr_t w;
        w.i_fmt.op  = op;
        w.i_fmt.rd  = rd;
        w.i_fmt.rs  = rs;
        w.i_fmt.imm = imm;
        emit_word(p, w);
    endtask

    task automatic expect_wb(input int p, input cpu_pkg::reg_t r, input cpu_pkg::word_t v);
        exp_reg[p][exp_cnt[p]]  = r;
        exp_data[p][exp_cnt[p]] = v;
        exp_cnt[p]++;
        shadow[r] = v;
    endtask

    task automatic build_table();
        logic [5:0] a;
        logic [5:0] b;
        logic [5:0] c;
        for (int p = 0; p < NPROG; p++) begin
            prog_len[p] = 0;
            exp_cnt[p]  = 0;
            exp_err[p]  = 1'b0;
        end
        for (int r = 0; r < 8; r++) begin
            shadow[r] = '0;
        end
        total_words = 0;

        // alu chain where each result feeds the next instruction
        prog_name[0] = "alu forwarding";
        a = draw_imm(1'b0);
        b = draw_imm(1'b0);
        emit_i(0, cpu_pkg::OP_ADDI, 3'd1, 3'd0, a);
        expect_wb(0, 3'd1, sext6(a));
        emit_i(0, cpu_pkg::OP_ADDI, 3'd2, 3'd0, b);
        expect_wb(0, 3'd2, sext6(b));
        emit_r(0, cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2);
        expect_wb(0, 3'd3, shadow[1] + shadow[2]);
        emit_r(0, cpu_pkg::OP_SUB, 3'd4, 3'd3, 3'd1);
        expect_wb(0, 3'd4, shadow[3] - shadow[1]);
        emit_r(0, cpu_pkg::OP_AND, 3'd5, 3'd4, 3'd3);
        expect_wb(0, 3'd5, shadow[4] & shadow[3]);
        emit_r(0, cpu_pkg::OP_XOR, 3'd6, 3'd5, 3'd4);
        expect_wb(0, 3'd6, shadow[5] ^ shadow[4]);
        emit_r(0, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);

        prog_name[1] = "addi sign extension";
        a = draw_imm(1'b1);
        b = draw_imm(1'b1);
        emit_i(1, cpu_pkg::OP_ADDI, 3'd1, 3'd0, a);
        expect_wb(1, 3'd1, sext6(a));
        emit_i(1, cpu_pkg::OP_ADDI, 3'd2, 3'd1, b);
        expect_wb(1, 3'd2, shadow[1] + sext6(b));
        emit_i(1, cpu_pkg::OP_ADDI, 3'd7, 3'd0, 6'h1f);
        expect_wb(1, 3'd7, 16'h001f);
        // 31 - 32 wraps to all ones
        emit_i(1, cpu_pkg::OP_ADDI, 3'd7, 3'd7, 6'h20);
        expect_wb(1, 3'd7, 16'hffff);
        emit_r(1, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);

        // store then load at address 8 with each load used right away
        prog_name[2] = "store load stall";
        c = draw_imm(1'b0);
        emit_i(2, cpu_pkg::OP_ADDI, 3'd1, 3'd0, 6'd5);
        expect_wb(2, 3'd1, 16'd5);
        emit_i(2, cpu_pkg::OP_ADDI, 3'd2, 3'd0, c);
        expect_wb(2, 3'd2, sext6(c));
        emit_i(2, cpu_pkg::OP_ST, 3'd2, 3'd1, 6'd3);
        emit_i(2, cpu_pkg::OP_LD, 3'd3, 3'd1, 6'd3);
        expect_wb(2, 3'd3, shadow[2]);
        emit_r(2, cpu_pkg::OP_ADD, 3'd4, 3'd3, 3'd3);
        expect_wb(2, 3'd4, shadow[3] + shadow[3]);
        emit_i(2, cpu_pkg::OP_LD, 3'd5, 3'd0, 6'd8);
        expect_wb(2, 3'd5, shadow[2]);
        emit_r(2, cpu_pkg::OP_XOR, 3'd6, 3'd5, 3'd1);
        expect_wb(2, 3'd6, shadow[5] ^ shadow[1]);
        emit_r(2, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);

        // r0 writes give no strobe
        prog_name[3] = "r0 writes";
        emit_i(3, cpu_pkg::OP_ADDI, 3'd0, 3'd0, 6'd9);
        emit_r(3, cpu_pkg::OP_ADD, 3'd0, 3'd1, 3'd2);
        emit_r(3, cpu_pkg::OP_ADD, 3'd1, 3'd0, 3'd0);
        expect_wb(3, 3'd1, 16'h0000);
        emit_i(3, cpu_pkg::OP_ADDI, 3'd2, 3'd0, 6'd7);
        expect_wb(3, 3'd2, 16'd7);
        emit_r(3, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);

        prog_name[4] = "illegal opcode";
        exp_err[4] = 1'b1;
        emit_i(4, cpu_pkg::OP_ADDI, 3'd1, 3'd0, 6'd3);
        expect_wb(4, 3'd1, 16'd3);
        emit_word(4, 16'h8000);
        emit_i(4, cpu_pkg::OP_ADDI, 3'd2, 3'd1, 6'd4);
        expect_wb(4, 3'd2, shadow[1] + 16'd4);
        emit_r(4, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);

        // operands left over from earlier runs
        prog_name[5] = "rerun persistence";
        emit_r(5, cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2);
        expect_wb(5, 3'd3, shadow[1] + shadow[2]);
        emit_r(5, cpu_pkg::OP_SUB, 3'd4, 3'd7, 3'd3);
        expect_wb(5, 3'd4, shadow[7] - shadow[3]);
        emit_r(5, cpu_pkg::OP_HALT, 3'd0, 3'd0, 3'd0);
    endtask

    task automatic check_wb(input cpu_pkg::reg_t got_reg, input cpu_pkg::word_t got_data,
                            input cpu_pkg::reg_t want_reg, input cpu_pkg::word_t want_data);
        if (got_reg !== want_reg) begin
            $display("FAIL o_wb_reg: got %h expected %h", got_reg, want_reg);
            errors++;
        end
        if (got_data !== want_data) begin
            $display("FAIL o_wb_data: got %h expected %h", got_data, want_data);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic run_program(input int p);
        cpu_pkg::reg_t   got_reg [$];
        cpu_pkg::word_t  got_data [$];
        logic            seen_err;
        logic            done;
        int              cycles;
        int              errs_before;
        errs_before = errors;
        for (int i = 0; i < prog_len[p]; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i[cpu_pkg::IMEM_AW-1:0];
            imem_data <= prog_word[p][i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        // sample on the falling edge between register updates
        seen_err = 1'b0;
        done     = 1'b0;
        cycles   = 0;
        while (!done && cycles < 2 * prog_len[p] + 12) begin
            @(negedge clk);
            cycles++;
            if (wb_valid) begin
                got_reg.push_back(wb_reg);
                got_data.push_back(wb_data);
            end
            if (err) begin
                seen_err = 1'b1;
            end
            done = halted;
        end

        if (!done) begin
            $display("test %0d never reached HALT within %0d cycles", p, cycles);
            errors++;
        end
        if (got_reg.size() != exp_cnt[p]) begin
            $display("test %0d expected %0d writebacks but saw %0d", p, exp_cnt[p],
                     got_reg.size());
            errors++;
        end
        for (int k = 0; k < exp_cnt[p] && k < got_reg.size(); k++) begin
            check_wb(got_reg[k], got_data[k], exp_reg[p][k], exp_data[p][k]);
        end
        check_flag("o_err", seen_err, exp_err[p]);

        if (errors == errs_before) begin
            pass_count++;
            $display("test %0d %s: ok", p, prog_name[p]);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d mismatches", p, prog_name[p], errors - errs_before);
        end
    endtask

    initial begin : main
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        start      = 1'b0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        table_ready = 1'b1;
        @(posedge rst_n);
        for (int p = 0; p < NPROG; p++) begin
            run_program(p);
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // budget grows with the number of table words
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RST_CYCLES + 20 + 3 * total_words;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/cpu_pkg.sv
common/stage_if.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
memory/memory.sv
verilog/hazard_unit.sv
verilog/cpu_top.sv
tb/tb_clock.sv
tb/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu \
    -f sources.f --Mdir obj_dir -o sim_cpu

./obj_dir/sim_cpu | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
